/* verilog.f */
+incdir+src
src/dma_cmd_pkg.sv
src/dma_bus_pkg.sv
src/dma_cmd_queue.sv
src/dma_csr.sv
src/dma_read_port.sv
src/dma_write_port.sv
src/dma_engine.sv
src/dma_top.sv
testbench/dma_checker.sv
testbench/tb_dma.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --timescale 1ns/1ps -j 0
TOP = tb_dma
FILELIST = verilog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_dma.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module tb_dma;
	localparam int RAND_CMDS = `DMA_QUEUE_DEPTH + 3;
	localparam int MEM_WORDS = 1024;

	logic clock = 1'b0;
	logic arst_n = 1'b0;
	dma_bus_pkg::axil_addr_t s_aw, s_ar, m_aw, m_ar;
	dma_bus_pkg::axil_wdata_t s_w, m_w;
	dma_bus_pkg::axil_bresp_t s_b, m_b;
	dma_bus_pkg::axil_rdata_t s_r, m_r;
	logic s_awready, s_wready, s_bready, s_arready, s_rready;
	logic m_awready, m_wready, m_bready, m_arready, m_rready;
	logic rd_check;
	logic [31:0] rd_expect;
	int chk_errors, chk_checks, chk_pending, chk_bus_reads, chk_bus_writes;

	logic [31:0] mem [MEM_WORDS];
	dma_cmd_pkg::dma_cmd_t fixed [5];
	dma_cmd_pkg::dma_cmd_t rnd [RAND_CMDS];
	int stall_max = 3;
	int word_budget = 0;
	logic budget_set = 1'b0;
	int pushed = 0;
	int tests = 0;
	int failures = 0;
	int own_checks = 0;
	int errors_at_start = 0;

	always #5 clock = ~clock;

	dma_top i_dut (
		.i_clock(clock), .i_arst_n(arst_n),
		.i_s_aw(s_aw), .o_s_awready(s_awready), .i_s_w(s_w), .o_s_wready(s_wready),
		.o_s_b(s_b), .i_s_bready(s_bready), .i_s_ar(s_ar), .o_s_arready(s_arready),
		.o_s_r(s_r), .i_s_rready(s_rready),
		.o_m_aw(m_aw), .i_m_awready(m_awready), .o_m_w(m_w), .i_m_wready(m_wready),
		.i_m_b(m_b), .o_m_bready(m_bready), .o_m_ar(m_ar), .i_m_arready(m_arready),
		.i_m_r(m_r), .o_m_rready(m_rready)
	);

	dma_checker i_checker (
		.i_clock(clock), .i_arst_n(arst_n),
		.i_s_aw(s_aw), .i_s_awready(s_awready), .i_s_w(s_w), .i_s_wready(s_wready),
		.i_s_ar(s_ar), .i_s_arready(s_arready), .i_s_r(s_r), .i_s_rready(s_rready),
		.i_m_aw(m_aw), .i_m_awready(m_awready), .i_m_w(m_w), .i_m_wready(m_wready),
		.i_m_ar(m_ar), .i_m_arready(m_arready),
		.i_rd_check(rd_check), .i_rd_expect(rd_expect),
		.o_errors(chk_errors), .o_checks(chk_checks), .o_pending(chk_pending),
		.o_bus_reads(chk_bus_reads), .o_bus_writes(chk_bus_writes)
	);

	function automatic logic [31:0] pattern_word(input logic [31:0] addr);
		return (addr * 32'h0001_0001) ^ 32'hA5A5_0F0F;
	endfunction

	function automatic dma_cmd_pkg::dma_cmd_t make_cmd(input dma_cmd_pkg::dma_op_t op,
			input logic [31:0] operand, input logic [31:0] dst, input logic [31:0] count);
		dma_cmd_pkg::dma_cmd_t cmd;
		cmd.op = op;
		cmd.operand.src_addr = operand;
		cmd.dst_addr = dst;
		cmd.count = count;
		cmd.tag = '0; // Assigned by the DUT on push
		return cmd;
	endfunction

	// Sources stay below 0x400, destinations in 0x800..0xFFF
	function automatic dma_cmd_pkg::dma_cmd_t random_cmd();
		dma_cmd_pkg::dma_op_t op;
		logic [31:0] count;
		logic [31:0] operand;
		logic [31:0] dst;
		op = dma_cmd_pkg::dma_op_t'(2'($urandom_range(3, 1)));
		count = $urandom_range(6, 1);
		dst = 32'h800 + 4 * $urandom_range(500, 0);
		operand = 4 * $urandom_range(240, 0);
		if (op == dma_cmd_pkg::OP_FILL)
			operand = $urandom();
		return make_cmd(op, operand, dst, count);
	endfunction

	function automatic int total_errors();
		return chk_errors + failures;
	endfunction

	task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clock);
		s_aw.valid <= 1'b1;
		s_aw.addr <= addr;
		s_w.valid <= 1'b1;
		s_w.data <= data;
		s_w.strb <= '1;
		@(posedge clock);
		while (!s_awready) @(posedge clock);
		s_aw.valid <= 1'b0;
		s_w.valid <= 1'b0;
		while (!s_b.valid) @(posedge clock);
	endtask

	task automatic cpu_read(input logic [31:0] addr, input logic check,
			input logic [31:0] expected, output logic [31:0] data);
		@(posedge clock);
		s_ar.valid <= 1'b1;
		s_ar.addr <= addr;
		rd_check <= check;
		rd_expect <= expected;
		@(posedge clock);
		while (!s_arready) @(posedge clock);
		s_ar.valid <= 1'b0;
		@(posedge clock);
		while (!s_r.valid) @(posedge clock);
		data = s_r.data;
	endtask

	task automatic queue_command(input dma_cmd_pkg::dma_cmd_t cmd);
		cpu_write(32'h0, cmd.operand.src_addr);
		cpu_write(32'h4, cmd.dst_addr);
		cpu_write(32'h8, cmd.count);
		cpu_write(32'hC, {30'd0, cmd.op}); // Stalls while the queue is full
		pushed++;
	endtask

	task automatic wait_idle();
		logic [31:0] busy;
		busy = '1;
		while (busy != 0)
			cpu_read(32'hC, 1'b0, '0, busy);
	endtask

	task automatic finish_test(input string name);
		logic [31:0] rdata;
		wait_idle();
		own_checks++;
		if (chk_pending != 0) begin
			failures++;
			$display("%s: %0d expected memory writes never happened", name, chk_pending);
		end
		cpu_read(32'h4, 1'b1, pushed, rdata);
		@(posedge clock); // Checker has counted the last read
		tests++;
		$display("test %0d %s: %0d errors", tests, name, total_errors() - errors_at_start);
		errors_at_start = total_errors();
	endtask

	task automatic serve_write();
		logic [31:0] addr;
		repeat ($urandom_range(stall_max, 0)) @(posedge clock);
		m_awready <= 1'b1;
		m_wready <= 1'b1;
		@(posedge clock); // AW and W taken together
		addr = m_aw.addr;
		mem[addr[11:2]] = m_w.data;
		m_awready <= 1'b0;
		m_wready <= 1'b0;
		repeat ($urandom_range(stall_max, 0)) @(posedge clock);
		m_b.valid <= 1'b1;
		m_b.resp <= 2'b00;
		@(posedge clock);
		while (!m_bready) @(posedge clock);
		m_b.valid <= 1'b0;
	endtask

	task automatic serve_read();
		logic [31:0] addr;
		repeat ($urandom_range(stall_max, 0)) @(posedge clock);
		m_arready <= 1'b1;
		@(posedge clock);
		addr = m_ar.addr;
		m_arready <= 1'b0;
		repeat ($urandom_range(stall_max, 0)) @(posedge clock);
		m_r.valid <= 1'b1;
		m_r.data <= mem[addr[11:2]];
		m_r.resp <= 2'b00;
		@(posedge clock);
		while (!m_rready) @(posedge clock);
		m_r.valid <= 1'b0;
	endtask

	initial begin : memory_write_side
		m_awready <= 1'b0;
		m_wready <= 1'b0;
		m_b <= '0;
		forever begin
			@(posedge clock);
			if (m_aw.valid)
				serve_write();
		end
	end

	initial begin : memory_read_side
		m_arready <= 1'b0;
		m_r <= '0;
		forever begin
			@(posedge clock);
			if (m_ar.valid)
				serve_read();
		end
	end

	initial begin : watchdog
		wait (budget_set);
		repeat (200 * word_budget + 1000) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", 200 * word_budget + 1000);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] rdata;
		int reads_before;
		int writes_before;
		void'($urandom(7));
		s_aw <= '0;
		s_w <= '0;
		s_ar <= '0;
		s_bready <= 1'b1;
		s_rready <= 1'b1;
		rd_check <= 1'b0;
		rd_expect <= '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = pattern_word(32'(i * 4));
		fixed[0] = make_cmd(dma_cmd_pkg::OP_FILL, 32'h1111_2222, 32'h800, 32'd3);
		fixed[1] = make_cmd(dma_cmd_pkg::OP_COPY, 32'h020, 32'h840, 32'd2);
		fixed[2] = make_cmd(dma_cmd_pkg::OP_FILL, 32'hC0DE_1234, 32'h900, 32'd8);
		fixed[3] = make_cmd(dma_cmd_pkg::OP_COPY, 32'h040, 32'hA00, 32'd6);
		fixed[4] = make_cmd(dma_cmd_pkg::OP_FEED, 32'h100, 32'hF00, 32'd5);
		for (int i = 0; i < RAND_CMDS; i++)
			rnd[i] = random_cmd();
		for (int i = 0; i < 5; i++)
			word_budget = word_budget + fixed[i].count;
		for (int i = 0; i < RAND_CMDS; i++)
			word_budget = word_budget + rnd[i].count;
		budget_set = 1'b1;
		repeat (2) @(posedge clock);
		arst_n <= 1'b1;

		queue_command(fixed[0]);
		queue_command(fixed[1]);
		cpu_read(32'h0, 1'b1, pushed, rdata);
		cpu_read(32'h8, 1'b1, fixed[1].count, rdata);
		finish_test("registers");
		queue_command(fixed[2]);
		finish_test("fill");
		queue_command(fixed[3]);
		finish_test("copy");
		queue_command(fixed[4]);
		finish_test("feed");

		stall_max = 10; // Slow memory so the queue fills up
		for (int i = 0; i < RAND_CMDS; i++)
			queue_command(rnd[i]);
		finish_test("back-pressure");
		stall_max = 3;

		reads_before = chk_bus_reads;
		writes_before = chk_bus_writes;
		queue_command(make_cmd(dma_cmd_pkg::OP_COPY, 32'h0, 32'hC00, 32'd0));
		queue_command(make_cmd(dma_cmd_pkg::OP_NONE, 32'h0, 32'hC00, 32'd4));
		wait_idle();
		own_checks++;
		if (chk_bus_reads != reads_before || chk_bus_writes != writes_before) begin
			failures++;
			$display("a zero-count or none command reached the memory bus");
		end
		finish_test("zero count and none");

		$display("%0d tests, %0d checks, %0d errors", tests, chk_checks + own_checks,
			total_errors());
		if (total_errors() == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* testbench/dma_checker.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_checker (
	input  logic                     i_clock,
	input  logic                     i_arst_n,
	input  dma_bus_pkg::axil_addr_t  i_s_aw,
	input  logic                     i_s_awready,
	input  dma_bus_pkg::axil_wdata_t i_s_w,
	input  logic                     i_s_wready,
	input  dma_bus_pkg::axil_addr_t  i_s_ar,
	input  logic                     i_s_arready,
	input  dma_bus_pkg::axil_rdata_t i_s_r,
	input  logic                     i_s_rready,
	input  dma_bus_pkg::axil_addr_t  i_m_aw,
	input  logic                     i_m_awready,
	input  dma_bus_pkg::axil_wdata_t i_m_w,
	input  logic                     i_m_wready,
	input  dma_bus_pkg::axil_addr_t  i_m_ar,
	input  logic                     i_m_arready,
	input  logic                     i_rd_check,
	input  logic [`DMA_DATA_W-1:0]   i_rd_expect,
	output int                       o_errors,
	output int                       o_checks,
	output int                       o_pending,
	output int                       o_bus_reads,
	output int                       o_bus_writes
);
	dma_cmd_pkg::dma_cmd_t staged = '0; // Mirror of the CSR staging registers
	logic [63:0] expected [$]; // {addr, data} in bus order
	logic [`DMA_ADDR_W-1:0] wr_addr;
	logic [`DMA_DATA_W-1:0] wr_data;
	logic [dma_bus_pkg::STRB_W-1:0] wr_strb;
	logic aw_seen = 1'b0;
	logic w_seen = 1'b0;
	logic [1:0] rd_reg = '0;
	int errors = 0;
	int checks = 0;
	int reads = 0;
	int writes = 0;

	assign o_errors = errors;
	assign o_checks = checks;
	assign o_pending = expected.size();
	assign o_bus_reads = reads;
	assign o_bus_writes = writes;

	function automatic logic [31:0] initial_word(input logic [31:0] addr);
		return (addr * 32'h0001_0001) ^ 32'hA5A5_0F0F;
	endfunction

	// Word k of a command as it should appear on the memory bus
	function automatic logic [63:0] reference_write(input dma_cmd_pkg::dma_cmd_t cmd,
			input int unsigned k);
		logic [31:0] step;
		logic [31:0] addr;
		logic [31:0] data;
		step = k * `DMA_WORD_STRIDE;
		addr = cmd.dst_addr + step;
		data = initial_word(cmd.operand.src_addr + step);
		if (cmd.op == dma_cmd_pkg::OP_FILL)
			data = cmd.operand.fill_value;
		else if (cmd.op == dma_cmd_pkg::OP_FEED)
			addr = cmd.dst_addr; // Fixed target
		return {addr, data};
	endfunction

	function automatic string reg_name(input logic [1:0] offset);
		case (offset)
			2'd0: return "queued";
			2'd1: return "retired_tag";
			2'd2: return "staged_count";
			default: return "busy";
		endcase
	endfunction

	task automatic note_cpu_write(input logic [1:0] offset, input logic [31:0] data);
		case (offset)
			2'd0: staged.operand.src_addr = data;
			2'd1: staged.dst_addr = data;
			2'd2: staged.count = data;
			default: begin
				staged.op = dma_cmd_pkg::dma_op_t'(data[1:0]);
				if (staged.op != dma_cmd_pkg::OP_NONE)
					for (int unsigned k = 0; k < staged.count; k++)
						expected.push_back(reference_write(staged, k));
			end
		endcase
	endtask

	task automatic check_value(input string name, input logic [31:0] want,
			input logic [31:0] got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, want, got);
		end
	endtask

	task automatic compare_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [31:0] strb);
		logic [63:0] want;
		writes++;
		check_value("m_w.strb", {dma_bus_pkg::STRB_W{1'b1}}, strb); // Full words only
		if (expected.size() == 0) begin
			errors++;
			$display("unexpected memory write at %0t to %h with data %h, none was due",
				$time, addr, data);
		end else begin
			want = expected.pop_front();
			check_value("m_aw.addr", want[63:32], addr);
			check_value("m_w.data", want[31:0], data);
		end
	endtask

	always @(posedge i_clock) begin
		if (i_arst_n) begin
			// AWREADY and WREADY rise as a pair
			if (i_s_awready || i_s_wready) begin
				check_value("s_awready", 32'd1, {31'd0, i_s_awready});
				check_value("s_wready", 32'd1, {31'd0, i_s_wready});
			end
			if (i_s_aw.valid && i_s_awready && i_s_w.valid && i_s_wready)
				note_cpu_write(i_s_aw.addr[3:2], i_s_w.data);
			if (i_m_aw.valid && i_m_awready) begin
				wr_addr = i_m_aw.addr;
				aw_seen = 1'b1;
			end
			if (i_m_w.valid && i_m_wready) begin
				wr_data = i_m_w.data;
				wr_strb = i_m_w.strb;
				w_seen = 1'b1;
			end
			if (aw_seen && w_seen) begin
				compare_write(wr_addr, wr_data, {28'd0, wr_strb});
				aw_seen = 1'b0;
				w_seen = 1'b0;
			end
			if (i_m_ar.valid && i_m_arready)
				reads++;
			if (i_s_ar.valid && i_s_arready)
				rd_reg = i_s_ar.addr[3:2];
			if (i_s_r.valid && i_s_rready && i_rd_check)
				check_value({"s_r.data ", reg_name(rd_reg)}, i_rd_expect, i_s_r.data);
		end
	end

endmodule

/* src/dma_top.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_top (
	input  logic                     i_clock,
	input  logic                     i_arst_n,
	// CPU register port
	input  dma_bus_pkg::axil_addr_t  i_s_aw,
	output logic                     o_s_awready,
	input  dma_bus_pkg::axil_wdata_t i_s_w,
	output logic                     o_s_wready,
	output dma_bus_pkg::axil_bresp_t o_s_b,
	input  logic                     i_s_bready,
	input  dma_bus_pkg::axil_addr_t  i_s_ar,
	output logic                     o_s_arready,
	output dma_bus_pkg::axil_rdata_t o_s_r,
	input  logic                     i_s_rready,
	// Memory port
	output dma_bus_pkg::axil_addr_t  o_m_aw,
	input  logic                     i_m_awready,
	output dma_bus_pkg::axil_wdata_t o_m_w,
	input  logic                     i_m_wready,
	input  dma_bus_pkg::axil_bresp_t i_m_b,
	output logic                     o_m_bready,
	output dma_bus_pkg::axil_addr_t  o_m_ar,
	input  logic                     i_m_arready,
	input  dma_bus_pkg::axil_rdata_t i_m_r,
	output logic                     o_m_rready
);
	dma_cmd_pkg::dma_cmd_t push_cmd;
	dma_cmd_pkg::dma_cmd_t head;
	dma_cmd_pkg::dma_retire_t retire;
	logic push, pop, empty, full, engine_busy;
	logic rd_req_valid, rd_req_ready, rd_done;
	logic wr_req_valid, wr_req_ready, wr_done;
	logic [`DMA_ADDR_W-1:0] rd_req_addr;
	logic [`DMA_ADDR_W-1:0] wr_req_addr;
	logic [`DMA_DATA_W-1:0] rd_data;
	logic [`DMA_DATA_W-1:0] wr_req_data;

	dma_csr i_csr (
		.i_clock, .i_arst_n,
		.i_aw(i_s_aw), .o_awready(o_s_awready), .i_w(i_s_w), .o_wready(o_s_wready),
		.o_b(o_s_b), .i_bready(i_s_bready), .i_ar(i_s_ar), .o_arready(o_s_arready),
		.o_r(o_s_r), .i_rready(i_s_rready),
		.o_push(push), .o_push_cmd(push_cmd), .i_full(full), .i_empty(empty),
		.i_retire(retire), .i_engine_busy(engine_busy)
	);

	dma_cmd_queue #(.DEPTH(`DMA_QUEUE_DEPTH)) i_queue (
		.i_clock, .i_arst_n,
		.i_push(push), .i_push_cmd(push_cmd), .i_pop(pop), .o_head(head),
		.o_empty(empty), .o_full(full)
	);

	dma_engine i_engine (
		.i_clock, .i_arst_n,
		.i_empty(empty), .o_pop(pop), .i_head(head),
		.o_rd_req_valid(rd_req_valid), .i_rd_req_ready(rd_req_ready),
		.o_rd_req_addr(rd_req_addr), .i_rd_done(rd_done), .i_rd_data(rd_data),
		.o_wr_req_valid(wr_req_valid), .i_wr_req_ready(wr_req_ready),
		.o_wr_req_addr(wr_req_addr), .o_wr_req_data(wr_req_data), .i_wr_done(wr_done),
		.o_retire(retire), .o_busy(engine_busy)
	);

	dma_read_port i_read_port (
		.i_clock, .i_arst_n,
		.i_req_valid(rd_req_valid), .o_req_ready(rd_req_ready), .i_req_addr(rd_req_addr),
		.o_done(rd_done), .o_data(rd_data),
		.o_ar(o_m_ar), .i_arready(i_m_arready), .i_r(i_m_r), .o_rready(o_m_rready)
	);

	dma_write_port i_write_port (
		.i_clock, .i_arst_n,
		.i_req_valid(wr_req_valid), .o_req_ready(wr_req_ready), .i_req_addr(wr_req_addr),
		.i_req_data(wr_req_data), .o_done(wr_done),
		.o_aw(o_m_aw), .i_awready(i_m_awready), .o_w(o_m_w), .i_wready(i_m_wready),
		.i_b(i_m_b), .o_bready(o_m_bready)
	);

endmodule

/* src/dma_engine.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_engine (
	input  logic                     i_clock,
	input  logic                     i_arst_n,
	input  logic                     i_empty,
	output logic                     o_pop,
	input  dma_cmd_pkg::dma_cmd_t    i_head,
	output logic                     o_rd_req_valid,
	input  logic                     i_rd_req_ready,
	output logic [`DMA_ADDR_W-1:0]   o_rd_req_addr,
	input  logic                     i_rd_done,
	input  logic [`DMA_DATA_W-1:0]   i_rd_data,
	output logic                     o_wr_req_valid,
	input  logic                     i_wr_req_ready,
	output logic [`DMA_ADDR_W-1:0]   o_wr_req_addr,
	output logic [`DMA_DATA_W-1:0]   o_wr_req_data,
	input  logic                     i_wr_done,
	output dma_cmd_pkg::dma_retire_t o_retire,
	output logic                     o_busy
);
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_READ_WAIT,
		ST_WRITE,
		ST_WRITE_WAIT,
		ST_RETIRE
	} state_t;

	state_t state;
	dma_cmd_pkg::dma_cmd_t cmd; // Active command, fields advance per word
	logic retire_valid;
	logic [`DMA_DATA_W-1:0] retire_tag;
	logic is_fill;

	assign is_fill = (cmd.op == dma_cmd_pkg::OP_FILL);
	assign o_pop = (state == ST_IDLE) && !i_empty;
	assign o_rd_req_valid = (state == ST_READ);
	assign o_rd_req_addr = cmd.operand.src_addr;
	assign o_wr_req_valid = (state == ST_WRITE);
	assign o_wr_req_addr = cmd.dst_addr;
	// Read data stays in the read port until the next read
	assign o_wr_req_data = is_fill ? cmd.operand.fill_value : i_rd_data;
	assign o_busy = (state != ST_IDLE) || retire_valid;

	always_comb begin
		o_retire.valid = retire_valid;
		o_retire.tag = retire_tag;
	end

	always_ff @(posedge i_clock) begin
		if (o_pop)
			cmd <= i_head;
		if (state == ST_READ_WAIT && i_rd_done)
			cmd.operand.src_addr <= cmd.operand.src_addr + `DMA_WORD_STRIDE;
		if (state == ST_WRITE_WAIT && i_wr_done) begin
			cmd.count <= cmd.count - 1'b1;
			if (cmd.op != dma_cmd_pkg::OP_FEED)
				cmd.dst_addr <= cmd.dst_addr + `DMA_WORD_STRIDE; // Feed keeps one address
		end
		if ((state == ST_WRITE_WAIT && i_wr_done && cmd.count == 'd1) || state == ST_RETIRE)
			retire_tag <= cmd.tag;
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= 1'b0;
			unique case (state)
				ST_IDLE: begin
					if (o_pop) begin
						if (i_head.op == dma_cmd_pkg::OP_NONE || i_head.count == '0)
							state <= ST_RETIRE; // No bus traffic
						else if (i_head.op == dma_cmd_pkg::OP_FILL)
							state <= ST_WRITE;
						else
							state <= ST_READ;
					end
				end
				ST_READ: if (i_rd_req_ready) state <= ST_READ_WAIT;
				ST_READ_WAIT: if (i_rd_done) state <= ST_WRITE;
				ST_WRITE: if (i_wr_req_ready) state <= ST_WRITE_WAIT;
				ST_WRITE_WAIT: begin
					if (i_wr_done) begin
						if (cmd.count == 'd1) begin
							retire_valid <= 1'b1;
							state <= ST_IDLE;
						end else
							state <= is_fill ? ST_WRITE : ST_READ;
					end
				end
				ST_RETIRE: begin
					retire_valid <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* src/dma_write_port.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_write_port (
	input  logic                     i_clock,
	input  logic                     i_arst_n,
	input  logic                     i_req_valid,
	output logic                     o_req_ready,
	input  logic [`DMA_ADDR_W-1:0]   i_req_addr,
	input  logic [`DMA_DATA_W-1:0]   i_req_data,
	output logic                     o_done,
	output dma_bus_pkg::axil_addr_t  o_aw,
	input  logic                     i_awready,
	output dma_bus_pkg::axil_wdata_t o_w,
	input  logic                     i_wready,
	input  dma_bus_pkg::axil_bresp_t i_b,
	output logic                     o_bready
);
	logic active;
	logic aw_pend;
	logic w_pend;
	logic [`DMA_ADDR_W-1:0] addr;
	logic [`DMA_DATA_W-1:0] data;

	assign o_req_ready = !active;
	assign o_bready = active && !aw_pend && !w_pend; // Both channels through

	always_comb begin
		o_aw.valid = aw_pend;
		o_aw.addr = addr;
		o_w.valid = w_pend;
		o_w.data = data;
		o_w.strb = '1;
	end

	always_ff @(posedge i_clock) begin
		if (i_req_valid && o_req_ready) begin
			addr <= i_req_addr;
			data <= i_req_data;
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			active <= 1'b0;
			aw_pend <= 1'b0;
			w_pend <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_req_valid && o_req_ready) begin
				active <= 1'b1;
				aw_pend <= 1'b1;
				w_pend <= 1'b1;
			end
			// AW and W may be taken in either order
			if (aw_pend && i_awready)
				aw_pend <= 1'b0;
			if (w_pend && i_wready)
				w_pend <= 1'b0;
			if (o_bready && i_b.valid) begin
				active <= 1'b0;
				o_done <= 1'b1;
			end
		end
	end

endmodule

/* src/dma_read_port.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_read_port (
	input  logic                     i_clock,
	input  logic                     i_arst_n,
	input  logic                     i_req_valid,
	output logic                     o_req_ready,
	input  logic [`DMA_ADDR_W-1:0]   i_req_addr,
	output logic                     o_done,
	output logic [`DMA_DATA_W-1:0]   o_data,
	output dma_bus_pkg::axil_addr_t  o_ar,
	input  logic                     i_arready,
	input  dma_bus_pkg::axil_rdata_t i_r,
	output logic                     o_rready
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_WAIT
	} state_t;

	state_t state;
	logic [`DMA_ADDR_W-1:0] addr;

	assign o_req_ready = (state == ST_IDLE);
	assign o_rready = (state == ST_WAIT);

	always_comb begin
		o_ar.valid = (state == ST_ADDR);
		o_ar.addr = addr;
	end

	always_ff @(posedge i_clock) begin
		if (i_req_valid && o_req_ready)
			addr <= i_req_addr;
		if (o_rready && i_r.valid)
			o_data <= i_r.data; // Response code ignored
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			unique case (state)
				ST_IDLE: if (i_req_valid) state <= ST_ADDR;
				ST_ADDR: if (i_arready) state <= ST_WAIT;
				ST_WAIT: begin
					if (i_r.valid) begin
						o_done <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* src/dma_csr.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_csr (
	input  logic                     i_clock,
	input  logic                     i_arst_n,
	input  dma_bus_pkg::axil_addr_t  i_aw,
	output logic                     o_awready,
	input  dma_bus_pkg::axil_wdata_t i_w,
	output logic                     o_wready,
	output dma_bus_pkg::axil_bresp_t o_b,
	input  logic                     i_bready,
	input  dma_bus_pkg::axil_addr_t  i_ar,
	output logic                     o_arready,
	output dma_bus_pkg::axil_rdata_t o_r,
	input  logic                     i_rready,
	output logic                     o_push,
	output dma_cmd_pkg::dma_cmd_t    o_push_cmd,
	input  logic                     i_full,
	input  logic                     i_empty,
	input  dma_cmd_pkg::dma_retire_t i_retire,
	input  logic                     i_engine_busy
);
	dma_cmd_pkg::dma_cmd_t staged;
	logic [`DMA_DATA_W-1:0] queued_cnt;
	logic [`DMA_DATA_W-1:0] retired_tag;
	logic wr_accept;
	logic rd_accept;
	logic wr_is_push;
	logic busy;

	assign wr_accept = o_awready && i_aw.valid && i_w.valid;
	assign rd_accept = o_arready && i_ar.valid;
	assign wr_is_push = (i_aw.addr[3:2] == 2'd3);
	assign busy = i_engine_busy || !i_empty;
	assign o_push_cmd = staged;

	// Staged command fields
	always_ff @(posedge i_clock) begin
		if (wr_accept) begin
			unique case (i_aw.addr[3:2])
				2'd0: staged.operand <= i_w.data;
				2'd1: staged.dst_addr <= i_w.data;
				2'd2: staged.count <= i_w.data;
				2'd3: begin
					staged.op <= dma_cmd_pkg::dma_op_t'(i_w.data[1:0]);
					staged.tag <= queued_cnt + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_b <= '0;
			o_push <= 1'b0;
			queued_cnt <= '0;
		end else begin
			o_push <= 1'b0;
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			// Hold off a push until the queue has room
			if (i_aw.valid && i_w.valid && !o_awready && !o_b.valid && !o_push &&
					!(wr_is_push && i_full)) begin
				o_awready <= 1'b1;
				o_wready <= 1'b1;
			end
			if (wr_accept) begin
				o_b.valid <= 1'b1;
				o_b.resp <= 2'b00;
				if (wr_is_push) begin
					o_push <= 1'b1;
					queued_cnt <= queued_cnt + 1'b1;
				end
			end else if (o_b.valid && i_bready)
				o_b.valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_arready <= 1'b0;
			o_r <= '0;
			retired_tag <= '0;
		end else begin
			if (i_retire.valid)
				retired_tag <= i_retire.tag;
			o_arready <= i_ar.valid && !o_arready && !o_r.valid;
			if (rd_accept) begin
				o_r.valid <= 1'b1;
				o_r.resp <= 2'b00;
				unique case (i_ar.addr[3:2])
					2'd0: o_r.data <= queued_cnt;
					2'd1: o_r.data <= retired_tag;
					2'd2: o_r.data <= staged.count;
					2'd3: o_r.data <= {`DMA_DATA_W{busy}}; // All ones while busy
				endcase
			end else if (o_r.valid && i_rready)
				o_r.valid <= 1'b0;
		end
	end

endmodule

/* src/dma_cmd_queue.sv */
`timescale 1ns/1ps

module dma_cmd_queue #(
	parameter int DEPTH = 8
) (
	input  logic                  i_clock,
	input  logic                  i_arst_n,
	input  logic                  i_push,
	input  dma_cmd_pkg::dma_cmd_t i_push_cmd,
	input  logic                  i_pop,
	output dma_cmd_pkg::dma_cmd_t o_head,
	output logic                  o_empty,
	output logic                  o_full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	dma_cmd_pkg::dma_cmd_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] used;
	logic do_push;
	logic do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	assign o_empty = (used == '0);
	assign o_full = (used == CNT_W'(DEPTH));
	assign o_head = mem[rd_ptr]; // Head visible without a pop

	always_ff @(posedge i_clock) begin
		if (do_push)
			mem[wr_ptr] <= i_push_cmd;
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				used <= used + 1'b1;
			else if (do_pop && !do_push)
				used <= used - 1'b1;
		end
	end

endmodule

/* src/dma_bus_pkg.sv */
`include "dma_params.svh"

package dma_bus_pkg;

	localparam int STRB_W = `DMA_DATA_W / 8;

	// AW and AR channels
	typedef struct packed {
		logic valid;
		logic [`DMA_ADDR_W-1:0] addr;
	} axil_addr_t;

	typedef struct packed {
		logic valid;
		logic [`DMA_DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axil_wdata_t;

	typedef struct packed {
		logic valid;
		logic [`DMA_DATA_W-1:0] data;
		logic [1:0] resp;
	} axil_rdata_t;

	typedef struct packed {
		logic valid;
		logic [1:0] resp;
	} axil_bresp_t;

endpackage

/* src/dma_cmd_pkg.sv */
`include "dma_params.svh"

package dma_cmd_pkg;

	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_FILL = 2'd1,
		OP_COPY = 2'd2,
		OP_FEED = 2'd3
	} dma_op_t;

	// Fill value for fill, source address for copy and feed
	typedef union packed {
		logic [`DMA_DATA_W-1:0] fill_value;
		logic [`DMA_ADDR_W-1:0] src_addr;
	} dma_operand_u;

	typedef struct packed {
		dma_op_t op;
		dma_operand_u operand;
		logic [`DMA_ADDR_W-1:0] dst_addr;
		logic [`DMA_DATA_W-1:0] count;
		logic [`DMA_DATA_W-1:0] tag;
	} dma_cmd_t;

	typedef struct packed {
		logic valid; // One cycle pulse
		logic [`DMA_DATA_W-1:0] tag;
	} dma_retire_t;

endpackage

/* src/dma_params.svh */
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Bus widths, one 32-bit word
`define DMA_ADDR_W 32
`define DMA_DATA_W 32

// Command queue entries
`define DMA_QUEUE_DEPTH 8

`define DMA_WORD_STRIDE 4 // Byte step per word

`endif
